// ==== Makefile ====
# Verilator build and run for the data-memory subsystem.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= tb_dmem
RTL_TOP    ?= dmem_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= rtl/dmem_pkg.sv rtl/dmem_wb_ram.sv rtl/dmem_lsu.sv rtl/dmem_top.sv
INC_DIRS   ?= +incdir+include

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(INC_DIRS) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/dmem_settings.svh ====
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// 12 bits of byte address give 4 KiB of data memory.
`define DM_ADDR_BIT 12

// word address width for the bank index and the debug port.
`define DM_WORD_ADDR_BIT (`DM_ADDR_BIT - 2)

// data width of the bus and of the core side.
// lane steering is written for four byte lanes, so this stays at 32.
`define DM_DATA_BIT 32

// number of byte lanes in one data word.
`define DM_LANES (`DM_DATA_BIT / 8)

`endif

// ==== rtl/dmem_lsu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_lsu
    import dmem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    output logic     req_ready,
    input  mem_req_t req,
    output logic     rsp_valid,
    output mem_rsp_t rsp,
    output wb_m2s_t  wb_out,
    input  wb_s2m_t  wb_in
);

    lsu_state_t state;
    mem_req_t   req_q;
    mem_rsp_t   rsp_q;

    logic                    accept;
    logic                    req_misaligned;
    logic [`DM_LANES-1:0]    sel;
    logic [`DM_DATA_BIT-1:0] store_data;
    logic [`DM_DATA_BIT-1:0] load_data;

    // picks the addressed byte or half from the bus word and extends it.
    function automatic logic [`DM_DATA_BIT-1:0] load_extend(
        input logic [`DM_DATA_BIT-1:0] word,
        input mem_size_t               size,
        input logic [1:0]              offset,
        input logic                    is_signed
    );
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        logic [`DM_DATA_BIT-1:0] result;
        byte_val = word[8*offset +: 8];
        half_val = offset[1] ? word[31:16] : word[15:0];
        case (size)
            size_byte: result = {{24{is_signed & byte_val[7]}}, byte_val};
            size_half: result = {{16{is_signed & half_val[15]}}, half_val};
            default:   result = word;
        endcase
        return result;
    endfunction

    assign req_ready = (state == st_idle);
    assign accept    = req_valid && req_ready;

    // a half must sit on an even address and a word on a multiple of four.
    always_comb begin
        case (req.size)
            size_byte: req_misaligned = 1'b0;
            size_half: req_misaligned = req.addr[0];
            default:   req_misaligned = (req.addr[1:0] != 2'b00);
        endcase
    end

    always_comb begin
        case (req_q.size)
            size_byte: begin
                sel        = 4'b0001 << req_q.addr[1:0];
                store_data = {4{req_q.wdata[7:0]}};
            end
            size_half: begin
                sel        = req_q.addr[1] ? 4'b1100 : 4'b0011;
                store_data = {2{req_q.wdata[15:0]}};
            end
            default: begin
                sel        = 4'b1111;
                store_data = req_q.wdata;
            end
        endcase
    end

    assign load_data = load_extend(wb_in.dat, req_q.size, req_q.addr[1:0], req_q.is_signed);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= req_misaligned ? st_resp : st_bus;
                    end
                end
                st_bus: begin
                    if (wb_in.ack) begin
                        state <= st_resp;
                    end
                end
                default: state <= st_idle; // st_resp lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
            if (req_misaligned) begin
                rsp_q <= '{rdata: '0, misaligned: 1'b1};
            end
        end
        if (state == st_bus && wb_in.ack) begin
            rsp_q.rdata      <= req_q.we ? '0 : load_data;
            rsp_q.misaligned <= 1'b0;
        end
    end

    assign rsp_valid = (state == st_resp);
    assign rsp       = rsp_q;

    // the bus cycle lasts exactly as long as st_bus.
    always_comb begin
        wb_out.cyc = (state == st_bus);
        wb_out.stb = (state == st_bus);
        wb_out.we  = req_q.we;
        wb_out.adr = req_q.addr[`DM_ADDR_BIT-1:2];
        wb_out.sel = sel;
        wb_out.dat = store_data;
    end

endmodule

`default_nettype wire

// ==== rtl/dmem_pkg.sv ====
`default_nettype none

`include "dmem_settings.svh"

package dmem_pkg;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    typedef enum logic [1:0] {
        st_idle,
        st_bus,
        st_resp
    } lsu_state_t;

    typedef struct packed {
        mem_size_t                   size;
        logic                        is_signed; // sign-extend loaded bytes and halves.
        logic                        we;
        logic [`DM_ADDR_BIT-1:0]     addr;
        logic [`DM_DATA_BIT-1:0]     wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`DM_DATA_BIT-1:0]     rdata;
        logic                        misaligned;
    } mem_rsp_t;

    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`DM_WORD_ADDR_BIT-1:0] adr;
        logic [`DM_LANES-1:0]        sel;
        logic [`DM_DATA_BIT-1:0]     dat;
    } wb_m2s_t;

    typedef struct packed {
        logic                        ack;
        logic [`DM_DATA_BIT-1:0]     dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

// ==== rtl/dmem_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_top
    import dmem_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  mem_req_t                     req,
    output logic                         rsp_valid,
    output mem_rsp_t                     rsp,
    input  logic [`DM_WORD_ADDR_BIT-1:0] dbg_addr,
    output logic [`DM_DATA_BIT-1:0]      dbg_data
);

    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;

    dmem_lsu i_dmem_lsu (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .wb_out    (wb_m2s),
        .wb_in     (wb_s2m)
    );

    dmem_wb_ram i_dmem_wb_ram (
        .clk      (clk),
        .rst      (rst),
        .wb_in    (wb_m2s),
        .wb_out   (wb_s2m),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

// ==== rtl/dmem_wb_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module dmem_wb_ram
    import dmem_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  wb_m2s_t                      wb_in,
    output wb_s2m_t                      wb_out,
    input  logic [`DM_WORD_ADDR_BIT-1:0] dbg_addr,
    output logic [`DM_DATA_BIT-1:0]      dbg_data
);

    localparam int DEPTH = 1 << `DM_WORD_ADDR_BIT;
    localparam int LANES = `DM_LANES;

    // lane 0 holds the least significant byte of each word.
    logic [7:0] bank [LANES][DEPTH];

    logic                    ack_q;
    logic [`DM_DATA_BIT-1:0] rd_q;
    logic                    access;

    // a held strobe is taken only once because ack_q blocks a second access.
    assign access = wb_in.cyc && wb_in.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && wb_in.we) begin
            for (int i = 0; i < LANES; i++) begin
                if (wb_in.sel[i]) begin
                    bank[i][wb_in.adr] <= wb_in.dat[8*i +: 8];
                end
            end
        end
    end

    // read data is registered together with ack, giving one wait state.
    always_ff @(posedge clk) begin
        if (access) begin
            for (int i = 0; i < LANES; i++) begin
                rd_q[8*i +: 8] <= bank[i][wb_in.adr];
            end
        end
    end

    always_comb begin
        wb_out.ack = ack_q;
        wb_out.dat = rd_q;
    end

    // the debug view reads any word straight from the banks.
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            dbg_data[8*i +: 8] = bank[i][dbg_addr];
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/dmem_pkg.sv
rtl/dmem_wb_ram.sv
rtl/dmem_lsu.sv
rtl/dmem_top.sv
tb/tb_dmem.sv

// ==== tb/tb_dmem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dmem_settings.svh"

module tb_dmem
    import dmem_pkg::*;
();

    localparam int AW      = `DM_ADDR_BIT;
    localparam int WAW     = `DM_WORD_ADDR_BIT;
    localparam int N_WORDS = 64;
    localparam int N_SUB   = 60;
    localparam int N_LOADS = 40;
    localparam int N_B2B   = 30;
    // every request and every debug read counts as one test.
    localparam int N_TESTS = 4 * N_WORDS + 2 * N_SUB + 26 + N_LOADS + 12 + N_B2B;
    localparam int WATCHDOG_CYCLES = N_TESTS * 6 + 200;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    logic                    req_ready;
    mem_req_t                req;
    logic                    rsp_valid;
    mem_rsp_t                rsp;
    logic [WAW-1:0]          dbg_addr;
    logic [`DM_DATA_BIT-1:0] dbg_data;

    logic [7:0]  shadow [1 << AW]; // byte image of the memory.
    logic [31:0] exp_rdata [$];
    logic        exp_mis [$];
    string       exp_name [$];
    string       test_name;
    string       rsp_name;
    int          value_errors = 0;
    int          timing_errors = 0;
    int          protocol_errors = 0;
    logic        accept;
    logic        req_mis;

    dmem_top i_dmem_top (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic is_misaligned(input mem_size_t sz, input logic [AW-1:0] addr);
        return (sz == size_half && addr[0]) || (sz == size_word && addr[1:0] != 2'b00);
    endfunction

    // the test region is spread so that the upper address bits toggle too.
    function automatic logic [WAW-1:0] word_at(input int i);
        return WAW'(i * 16 + i % 16);
    endfunction

    function automatic int rnd(input int n);
        return int'($urandom % n);
    endfunction

    function automatic logic [31:0] expected_load(input mem_req_t r);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = shadow[r.addr];
        hi = shadow[{r.addr[AW-1:1], 1'b1}];
        if (r.size == size_byte) begin
            return r.is_signed ? {{24{lo[7]}}, lo} : {24'h0, lo};
        end
        if (r.size == size_half) begin
            return r.is_signed ? {{16{hi[7]}}, hi, lo} : {16'h0, hi, lo};
        end
        return {shadow[{r.addr[AW-1:2], 2'b11}], shadow[{r.addr[AW-1:2], 2'b10}], hi, lo};
    endfunction

    function automatic void store_shadow(input mem_req_t r);
        shadow[r.addr] = r.wdata[7:0];
        if (r.size != size_byte) begin
            shadow[{r.addr[AW-1:1], 1'b1}] = r.wdata[15:8];
        end
        if (r.size == size_word) begin
            shadow[{r.addr[AW-1:2], 2'b10}] = r.wdata[23:16];
            shadow[{r.addr[AW-1:2], 2'b11}] = r.wdata[31:24];
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // returns one ns after the edge that accepts the request.
    task automatic send(input mem_size_t sz, input logic sgn, input logic wr,
                        input logic [AW-1:0] addr, input logic [31:0] wdata);
        logic ready_seen;
        req       = '{size: sz, is_signed: sgn, we: wr, addr: addr, wdata: wdata};
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            ready_seen = req_ready;
            @(posedge clk);
        end while (!ready_seen);
        #1;
    endtask

    task automatic finish_requests();
        req_valid = 1'b0;
        while (exp_rdata.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic access(input mem_size_t sz, input logic sgn, input logic wr,
                          input logic [AW-1:0] addr, input logic [31:0] wdata);
        send(sz, sgn, wr, addr, wdata);
        finish_requests();
    endtask

    task automatic check_word(input int i);
        dbg_addr = word_at(i);
        @(negedge clk);
        check_value($sformatf("%s dbg word %0d", test_name, i),
                    {shadow[{dbg_addr, 2'b11}], shadow[{dbg_addr, 2'b10}],
                     shadow[{dbg_addr, 2'b01}], shadow[{dbg_addr, 2'b00}]}, dbg_data);
        @(posedge clk);
        #1;
    endtask

    // responses are compared and new requests recorded at the falling edge.
    always @(negedge clk) begin
        if (!rst && rsp_valid) begin
            if (exp_rdata.size() == 0) begin
                protocol_errors++;
                $display("a response arrived with no request outstanding at %0t", $time);
            end else begin
                rsp_name = exp_name.pop_front();
                check_value({rsp_name, " rdata"}, exp_rdata.pop_front(), rsp.rdata);
                check_value({rsp_name, " misaligned"}, {31'h0, exp_mis.pop_front()},
                            {31'h0, rsp.misaligned});
            end
        end
        if (!rst && req_valid && req_ready) begin
            exp_name.push_back(test_name);
            exp_mis.push_back(req_mis);
            if (req_mis || req.we) begin
                exp_rdata.push_back(32'h0);
            end else begin
                exp_rdata.push_back(expected_load(req));
            end
            if (!req_mis && req.we) begin
                store_shadow(req);
            end
        end
    end

    assign accept  = req_valid && req_ready;
    assign req_mis = is_misaligned(req.size, req.addr);

    a_aligned_latency: assert property (@(posedge clk) disable iff (rst)
        (accept && !req_mis) |-> ##1 (!rsp_valid && !req_ready) ##1
        (!rsp_valid && !req_ready) ##1 (rsp_valid && !req_ready))
    else begin
        timing_errors++;
        $display("aligned request at %0t did not respond after exactly two cycles", $time);
    end

    a_misaligned_latency: assert property (@(posedge clk) disable iff (rst)
        (accept && req_mis) |-> ##1 (rsp_valid && !req_ready))
    else begin
        timing_errors++;
        $display("misaligned request at %0t did not respond in the next cycle", $time);
    end

    a_rsp_pulse: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> ##1 (!rsp_valid && req_ready))
    else begin
        timing_errors++;
        $display("rsp_valid was not a single-cycle pulse at %0t", $time);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int         idx;
        logic [1:0] off;
        void'($urandom(32'h2ecf_e495));
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        dbg_addr  = '0;
        test_name = "reset";
        for (int c = 0; c < 15; c++) begin
            @(negedge clk);
            check_value("reset req_ready", 32'h1, {31'h0, req_ready});
            check_value("reset rsp_valid", 32'h0, {31'h0, rsp_valid});
        end
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_value("after reset req_ready", 32'h1, {31'h0, req_ready});
        check_value("after reset rsp_valid", 32'h0, {31'h0, rsp_valid});
        @(posedge clk);
        #1;

        test_name = "word round trip";
        for (int i = 0; i < N_WORDS; i++)
            access(size_word, 1'b0, 1'b1, {word_at(i), 2'b00}, $urandom);
        for (int i = 0; i < N_WORDS; i++)
            access(size_word, 1'b0, 1'b0, {word_at(i), 2'b00}, 32'h0);
        for (int i = 0; i < N_WORDS; i++)
            check_word(i);

        test_name = "sub-word store";
        for (int n = 0; n < N_SUB; n++) begin
            idx = rnd(N_WORDS);
            off = 2'($urandom);
            if (n % 2 == 0) begin
                access(size_byte, 1'b0, 1'b1, {word_at(idx), off}, $urandom);
            end else begin
                access(size_half, 1'b0, 1'b1, {word_at(idx), off[1], 1'b0}, $urandom);
            end
            check_word(idx);
        end

        // both words hold bytes and halves with the top bit set and clear.
        test_name = "load extension";
        access(size_word, 1'b0, 1'b1, {word_at(5), 2'b00}, 32'h807f_ff01);
        access(size_word, 1'b0, 1'b1, {word_at(6), 2'b00}, 32'h7f80_01fe);
        for (int w = 5; w < 7; w++) begin
            for (int o = 0; o < 4; o++) begin
                for (int s = 0; s < 2; s++) begin
                    access(size_byte, s[0], 1'b0, {word_at(w), o[1:0]}, 32'h0);
                    if (!o[0]) begin
                        access(size_half, s[0], 1'b0, {word_at(w), o[1:0]}, 32'h0);
                    end
                end
            end
        end
        for (int n = 0; n < N_LOADS; n++) begin
            idx = rnd(N_WORDS);
            off = 2'($urandom);
            if (n % 2 == 1) begin
                access(size_half, 1'($urandom), 1'b0, {word_at(idx), off[1], 1'b0}, 32'h0);
            end else begin
                access(size_byte, 1'($urandom), 1'b0, {word_at(idx), off}, 32'h0);
            end
        end

        test_name = "misaligned";
        for (int o = 1; o < 4; o++) begin
            if (o != 2) begin
                access(size_half, 1'b1, 1'b0, {word_at(7), o[1:0]}, 32'h0);
                access(size_half, 1'b0, 1'b1, {word_at(7), o[1:0]}, 32'hdead_beef);
            end
            access(size_word, 1'b0, 1'b0, {word_at(7), o[1:0]}, 32'h0);
            access(size_word, 1'b0, 1'b1, {word_at(7), o[1:0]}, 32'hcafe_f00d);
        end
        check_word(7);
        check_word(8);

        test_name = "back-to-back";
        for (int n = 0; n < N_B2B; n++) begin
            idx = rnd(N_WORDS);
            send(mem_size_t'(rnd(3)), 1'($urandom), 1'($urandom),
                 {word_at(idx), 2'($urandom)}, $urandom); // req_valid stays high.
        end
        finish_requests();
        for (int i = 0; i < N_WORDS; i++)
            check_word(i);

        $display("errors: value %0d, timing %0d, protocol %0d",
                 value_errors, timing_errors, protocol_errors);
        if (value_errors + timing_errors + protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
